//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps
TOP       := fetchUnitTb
FILELIST  := all.f
OBJDIR    := obj_dir
PASSMSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASSMSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- all.f
+incdir+.
fetchPkg.sv
wbPkg.sv
fetchIfs.sv
nextPcStage.sv
branchTargetBuffer.sv
fetchControl.sv
wbFetchPort.sv
fetchUnit.sv
instrMemModel.sv
fetchUnitTb.sv

//--- branchTargetBuffer.sv
//------------------------------
// Direct-mapped BTB. Each slot PC is looked up in
// the same cycle; updates land at the clock edge.
//------------------------------
`timescale 1ns/1ps
`include "fetch_defs.svh"

module branchTargetBuffer (
    input  logic            clock,
    input  logic            rst,
    input  logic            updValid,
    input  fetchPkg::PcPath updPc,
    input  fetchPkg::PcPath updTarget,
    input  logic            updTaken,
    btbLookupIf.btb         lookup
);
    import fetchPkg::*;

    BtbEntry entries [`BTB_ENTRIES];

    // Index from the word address, tag from the bits above it
    function automatic BtbIndex indexOf(PcPath pc);
        return pc[insnOffBits +: btbIdxBits];
    endfunction

    function automatic BtbTag tagOf(PcPath pc);
        return pc[31 -: btbTagBits];
    endfunction

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (updValid) begin
            entries[indexOf(updPc)] <= '{
                valid:  1'b1,
                tag:    tagOf(updPc),
                target: updTarget,
                taken:  updTaken
            };
        end
    end

    for (genvar g = 0; g < `FETCH_WIDTH; g++) begin : gLookup
        BtbEntry slotEntry;

        assign slotEntry = entries[indexOf(lookup.slotPc[g])];
        assign lookup.hit[g] = slotEntry.valid && (slotEntry.tag == tagOf(lookup.slotPc[g]));
        assign lookup.taken[g] = slotEntry.taken;
        assign lookup.target[g] = slotEntry.target;
    end

    // Branches sit on word boundaries, so the low bits carry no index info
    updAligned: assert property (
        @(posedge clock) disable iff (rst)
        updValid |-> (updPc[insnOffBits-1:0] == '0)
    );

endmodule

//--- fetchControl.sv
//------------------------------
// Fetch sequencing FSM. Hands groups to the bus
// port, advances the PC and drains on a redirect.
//------------------------------
`timescale 1ns/1ps

module fetchControl (
    input  logic  clock,
    input  logic  rst,
    input  logic  redirectValid,
    output logic  pcWrite,
    groupIf.ctrl  grp
);

    typedef enum logic [1:0] {
        ctlIdle,
        ctlBusy,
        ctlDrain
    } CtrlState;

    CtrlState state;

    // Take and PC advance happen together, so one group is queued behind the port
    assign grp.groupTake = (state == ctlIdle) && grp.portIdle && !redirectValid;
    assign grp.redirectDrop = redirectValid;
    assign pcWrite = redirectValid || grp.groupTake;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= ctlIdle;
        end else if (redirectValid) begin
            state <= ctlDrain;
        end else begin
            case (state)
                ctlIdle: if (grp.groupTake) state <= ctlBusy;
                ctlBusy: if (grp.groupDone) state <= ctlIdle;
                // wait for an open bus cycle to finish
                ctlDrain: if (grp.portIdle) state <= ctlIdle;
                default: state <= ctlIdle;
            endcase
        end
    end

    // The port must accept the group it is given
    takeOnIdle: assert property (
        @(posedge clock) disable iff (rst)
        grp.groupTake |-> grp.portIdle ##1 !grp.portIdle
    );

endmodule

//--- fetchIfs.sv
//------------------------------
// Interfaces inside the fetch unit: BTB lookup
// per slot, and the group hand-off to the bus port.
//------------------------------
`timescale 1ns/1ps
`include "fetch_defs.svh"

interface btbLookupIf;
    import fetchPkg::*;

    PcPath slotPc [`FETCH_WIDTH];
    logic  hit    [`FETCH_WIDTH];
    logic  taken  [`FETCH_WIDTH];
    PcPath target [`FETCH_WIDTH];

    modport stage (output slotPc, input hit, input taken, input target);
    modport btb (input slotPc, output hit, output taken, output target);
endinterface

interface groupIf;
    import fetchPkg::*;

    FetchSlot groupSlots [`FETCH_WIDTH];
    logic     groupTake;
    logic     redirectDrop;
    logic     portIdle;
    logic     groupDone;

    modport stage (output groupSlots);
    modport ctrl (output groupTake, output redirectDrop, input portIdle, input groupDone);
    modport port (input groupSlots, input groupTake, input redirectDrop,
                  output portIdle, output groupDone);
endinterface

//--- fetchPkg.sv
//------------------------------
// Fetch-side types: PC, fetch slot, BTB entry,
// and the line boundary check used for grouping.
//------------------------------
`include "fetch_defs.svh"

package fetchPkg;

    localparam int insnOffBits = $clog2(`INSN_BYTES);
    localparam int lineOffBits = $clog2(`LINE_BYTES);
    localparam int btbIdxBits = $clog2(`BTB_ENTRIES);
    localparam int btbTagBits = 32 - btbIdxBits - insnOffBits;

    typedef logic [31:0] PcPath;
    typedef logic [btbIdxBits-1:0] BtbIndex;
    typedef logic [btbTagBits-1:0] BtbTag;
    typedef logic [$clog2(`FETCH_WIDTH)-1:0] SlotIdx;

    typedef struct packed {
        logic  valid;
        PcPath pc;
        logic  predTaken;
    } FetchSlot;

    typedef struct packed {
        logic  valid;
        BtbTag tag;
        PcPath target;
        logic  taken;
    } BtbEntry;

    // True when the two PCs fall in different instruction lines
    function automatic logic stepsOverLine(PcPath pcA, PcPath pcB);
        return pcA[31:lineOffBits] != pcB[31:lineOffBits];
    endfunction

endpackage

//--- fetchUnit.sv
//------------------------------
// Fetch front end top level. Joins the next-PC
// stage, BTB, control FSM and Wishbone port.
//------------------------------
`timescale 1ns/1ps

module fetchUnit (
    input  logic            clock,
    input  logic            rst,
    input  logic            redirectValid,
    input  fetchPkg::PcPath redirectPc,
    input  logic            btbUpdValid,
    input  fetchPkg::PcPath btbUpdPc,
    input  fetchPkg::PcPath btbUpdTarget,
    input  logic            btbUpdTaken,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output wbPkg::WbAddr    wbAdr,
    output wbPkg::WbSel     wbSel,
    input  wbPkg::WbData    wbDatIn,
    input  logic            wbAck,
    output logic            outValid,
    input  logic            outReady,
    output fetchPkg::PcPath outPc,
    output wbPkg::WbData    outInsn,
    output logic            outPredTaken
);

    logic pcWrite;

    btbLookupIf btbIf ();
    groupIf     grpIf ();

    nextPcStage stage0 (
        .clock(clock), .rst(rst), .pcWrite(pcWrite), .redirectValid(redirectValid),
        .redirectPc(redirectPc), .btb(btbIf.stage), .grp(grpIf.stage)
    );

    branchTargetBuffer btb0 (
        .clock(clock), .rst(rst), .updValid(btbUpdValid), .updPc(btbUpdPc),
        .updTarget(btbUpdTarget), .updTaken(btbUpdTaken), .lookup(btbIf.btb)
    );

    fetchControl ctrl0 (
        .clock(clock), .rst(rst), .redirectValid(redirectValid), .pcWrite(pcWrite),
        .grp(grpIf.ctrl)
    );

    wbFetchPort port0 (
        .clock(clock), .rst(rst), .grp(grpIf.port),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbSel(wbSel),
        .wbDatIn(wbDatIn), .wbAck(wbAck),
        .outValid(outValid), .outReady(outReady), .outPc(outPc), .outInsn(outInsn),
        .outPredTaken(outPredTaken)
    );

endmodule

//--- fetchUnitTb.sv
//------------------------------
// Testbench for the fetch unit. Runs a table of
// scenarios against a PC-walk reference model and
// checks the Wishbone and valid/ready rules.
//------------------------------
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetchUnitTb;

    localparam logic [31:0] memKey = 32'hA5C3_0F69;
    localparam int nRows = 5;
    localparam int cycleLimit = 400;

    typedef struct packed {
        int          nTrain;
        logic [31:0] brPcA;
        logic [31:0] tgtA;
        logic        takenA;
        logic [31:0] brPcB;
        logic [31:0] tgtB;
        logic        takenB;
        logic        redirOn;
        int          redirCycle;
        logic [31:0] redirPc;
        logic        stallOn;
        int          outCount;
    } StimRow;

    logic        clock;
    logic        rst;
    logic        redirectValid;
    logic [31:0] redirectPc;
    logic        btbUpdValid;
    logic [31:0] btbUpdPc;
    logic [31:0] btbUpdTarget;
    logic        btbUpdTaken;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [31:0] wbAdr;
    logic [3:0]  wbSel;
    logic [31:0] wbDatIn;
    logic        wbAck;
    logic        outValid;
    logic        outReady;
    logic [31:0] outPc;
    logic [31:0] outInsn;
    logic        outPredTaken;

    StimRow      stim [nRows];
    int          errors;
    int          outputsChecked;

    fetchUnit dut0 (.*);

    instrMemModel #(.dataKey(memKey)) mem0 (
        .clock(clock), .rst(rst), .cyc(wbCyc), .stb(wbStb), .we(wbWe),
        .adr(wbAdr), .datOut(wbDatIn), .ack(wbAck)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic reportFailure(input string msg);
        $display("Failure at %0t: %s", $time, msg);
        errors++;
    endtask

    // Group boundaries keep slot order, so the model steps one instruction at a time
    function automatic logic isTakenBranch(StimRow r, logic [31:0] pc);
        return ((r.nTrain >= 1) && (pc == r.brPcA) && r.takenA)
            || ((r.nTrain >= 2) && (pc == r.brPcB) && r.takenB);
    endfunction

    function automatic logic [31:0] followingPc(StimRow r, logic [31:0] pc);
        if ((r.nTrain >= 1) && (pc == r.brPcA) && r.takenA) begin
            return r.tgtA;
        end
        if ((r.nTrain >= 2) && (pc == r.brPcB) && r.takenB) begin
            return r.tgtB;
        end
        return pc + 32'd4;
    endfunction

    task automatic runRow(input int idx);
        StimRow      row;
        int          cycle;
        int          accepted;
        int          postCount;
        int          quietCycle;
        logic [31:0] modelPc;
        logic [31:0] ackAdr;
        logic        prevValid;
        logic        prevStall;
        logic [31:0] prevPc;
        logic [31:0] prevInsn;

        row = stim[idx];
        cycle = 0;
        accepted = 0;
        postCount = 0;
        quietCycle = -1;
        modelPc = `RESET_PC;
        ackAdr = '0;
        prevValid = 1'b0;
        prevStall = 1'b0;
        prevPc = '0;
        prevInsn = '0;

        // Reset also clears the BTB left over from the previous row
        @(posedge clock);
        rst <= 1'b1;
        redirectValid <= 1'b0;
        btbUpdValid <= 1'b0;
        outReady <= 1'b1;
        repeat (8) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        if (outValid !== 1'b0 || wbCyc !== 1'b0 || wbStb !== 1'b0) begin
            reportFailure("bus or output not idle at the end of reset");
        end

        while (accepted < row.outCount && cycle < cycleLimit) begin
            @(posedge clock);
            btbUpdValid <= (cycle < row.nTrain);
            btbUpdPc <= (cycle == 0) ? row.brPcA : row.brPcB;
            btbUpdTarget <= (cycle == 0) ? row.tgtA : row.tgtB;
            btbUpdTaken <= (cycle == 0) ? row.takenA : row.takenB;
            redirectValid <= row.redirOn && (cycle == row.redirCycle);
            redirectPc <= row.redirPc;
            outReady <= row.stallOn ? ($urandom_range(2, 0) != 0) : 1'b1;

            @(negedge clock);
            if (wbStb && !wbCyc) begin
                reportFailure("wbStb high without wbCyc");
            end
            if (wbWe !== 1'b0) begin
                reportMismatch("wbWe", {31'b0, wbWe}, 32'h0);
            end
            if (wbSel !== 4'hF) begin
                reportMismatch("wbSel", {28'b0, wbSel}, 32'hF);
            end
            if (wbCyc && wbAdr[1:0] != 2'b00) begin
                reportFailure("wbAdr is not word aligned");
            end
            if (wbStb && wbAck) begin
                ackAdr = wbAdr;
            end
            // A fresh output carries the word of the last acked address
            if (outValid && !prevValid && outPc !== ackAdr) begin
                reportMismatch("outPc against wbAdr", outPc, ackAdr);
            end
            if (prevStall && outValid) begin
                if (outPc !== prevPc) begin
                    reportMismatch("outPc under stall", outPc, prevPc);
                end
                if (outInsn !== prevInsn) begin
                    reportMismatch("outInsn under stall", outInsn, prevInsn);
                end
            end
            if (cycle == quietCycle && outValid) begin
                reportFailure("outValid still high in the cycle after the redirect");
            end

            if (outValid && outReady) begin
                if (outPc !== modelPc) begin
                    reportMismatch("outPc", outPc, modelPc);
                end
                if (outInsn !== (modelPc ^ memKey)) begin
                    reportMismatch("outInsn", outInsn, modelPc ^ memKey);
                end
                if (outPredTaken !== isTakenBranch(row, modelPc)) begin
                    reportMismatch("outPredTaken", {31'b0, outPredTaken},
                                   {31'b0, isTakenBranch(row, modelPc)});
                end
                outputsChecked++;
                accepted++;
                if (quietCycle >= 0) begin
                    postCount++;
                end
                modelPc = followingPc(row, modelPc);
            end
            // Output accepted in the pulse cycle still belongs to the old path
            if (redirectValid) begin
                modelPc = row.redirPc;
                quietCycle = cycle + 1;
            end

            prevValid = outValid;
            prevStall = outValid && !outReady;
            prevPc = outPc;
            prevInsn = outInsn;
            cycle++;
        end

        if (accepted < row.outCount) begin
            reportFailure($sformatf("timeout in row %0d, only %0d of %0d outputs accepted",
                                    idx, accepted, row.outCount));
        end
        if (row.redirOn && postCount == 0) begin
            reportFailure($sformatf("no output from the redirect path in row %0d", idx));
        end
    endtask

    initial begin
        void'($urandom(25156));
        errors = 0;
        outputsChecked = 0;
        rst = 1'b1;
        redirectValid = 1'b0;
        redirectPc = '0;
        btbUpdValid = 1'b0;
        btbUpdPc = '0;
        btbUpdTarget = '0;
        btbUpdTaken = 1'b0;
        outReady = 1'b1;

        // nTrain, brPcA, tgtA, takenA, brPcB, tgtB, takenB,
        // redirOn, redirCycle, redirPc, stallOn, outCount
        stim[0] = '{0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 0, 32'h0, 1'b0, 12};
        stim[1] = '{2, 32'h108, 32'h200, 1'b1, 32'h204, 32'h300, 1'b0,
                    1'b0, 0, 32'h0, 1'b0, 8};
        stim[2] = '{0, 32'h0, 32'h0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b1, 15, 32'h400, 1'b0, 10};
        stim[3] = '{1, 32'h10C, 32'h180, 1'b1, 32'h0, 32'h0, 1'b0,
                    1'b0, 0, 32'h0, 1'b1, 10};
        stim[4] = '{1, 32'h508, 32'h104, 1'b1, 32'h0, 32'h0, 1'b0,
                    1'b1, 20, 32'h500, 1'b1, 10};

        for (int r = 0; r < nRows; r++) begin
            runRow(r);
        end

        $display("Outputs checked: %0d, errors: %0d", outputsChecked, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- fetch_defs.svh
//------------------------------
// Sizes shared by the fetch front end.
// Include wherever slot counts, line size or the
// reset PC are needed.
//------------------------------
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Slots per fetch group
`define FETCH_WIDTH 2
`define INSN_BYTES 4

// A group never crosses a line of this size
`define LINE_BYTES 16
`define BTB_ENTRIES 16
`define RESET_PC 32'h0000_0100

`endif

//--- instrMemModel.sv
//------------------------------
// Wishbone slave memory for the testbench.
// Read data is the address XOR a key, and the
// ack comes after a random 0 to 3 cycle delay.
//------------------------------
`timescale 1ns/1ps

module instrMemModel #(
    parameter logic [31:0] dataKey = 32'h0
) (
    input  logic        clock,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    output logic [31:0] datOut = '0,
    output logic        ack = 1'b0
);

    logic waiting;
    int   waitLeft;

    always @(posedge clock) begin : ackGen
        int delay;
        if (rst) begin
            ack <= 1'b0;
            datOut <= '0;
            waiting <= 1'b0;
            waitLeft <= 0;
        end else if (ack) begin
            // Master drops the strobe on the ack edge
            ack <= 1'b0;
        end else if (cyc && stb && !we) begin
            if (!waiting) begin
                delay = int'($urandom_range(3, 0));
                if (delay == 0) begin
                    ack <= 1'b1;
                    datOut <= adr ^ dataKey;
                end else begin
                    waiting <= 1'b1;
                    waitLeft <= delay - 1;
                end
            end else if (waitLeft == 0) begin
                ack <= 1'b1;
                datOut <= adr ^ dataKey;
                waiting <= 1'b0;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

endmodule

//--- nextPcStage.sv
//------------------------------
// Next-PC stage. Holds the fetch PC, forms the
// current group and picks the following PC from
// a redirect, a taken BTB hit or the sequential path.
//------------------------------
`timescale 1ns/1ps
`include "fetch_defs.svh"

module nextPcStage (
    input  logic            clock,
    input  logic            rst,
    input  logic            pcWrite,
    input  logic            redirectValid,
    input  fetchPkg::PcPath redirectPc,
    btbLookupIf.stage       btb,
    groupIf.stage           grp
);
    import fetchPkg::*;

    PcPath    pc;
    PcPath    slotPc [`FETCH_WIDTH];
    FetchSlot slots  [`FETCH_WIDTH];
    PcPath    predNextPc;
    PcPath    nextPc;
    logic     takenSeen;

    for (genvar g = 0; g < `FETCH_WIDTH; g++) begin : gSlot
        assign slotPc[g] = pc + PcPath'(g * `INSN_BYTES);
        assign btb.slotPc[g] = slotPc[g];
        assign grp.groupSlots[g] = slots[g];
    end

    // Slots after a line crossing or after a taken prediction are invalid
    always_comb begin
        takenSeen = 1'b0;
        predNextPc = pc;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slots[i].pc = slotPc[i];
            slots[i].valid = !takenSeen && !stepsOverLine(pc, slotPc[i]);
            slots[i].predTaken = slots[i].valid && btb.hit[i] && btb.taken[i];
            // Last valid slot decides where fetch continues
            if (slots[i].valid) begin
                if (slots[i].predTaken) begin
                    predNextPc = btb.target[i];
                end else begin
                    predNextPc = slotPc[i] + PcPath'(`INSN_BYTES);
                end
            end
            if (slots[i].predTaken) begin
                takenSeen = 1'b1;
            end
        end
    end

    // Back-end redirect wins over any prediction
    assign nextPc = redirectValid ? redirectPc : predNextPc;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (pcWrite) begin
            pc <= nextPc;
        end
    end

    // A group always carries at least its first instruction, on a word boundary
    slotZeroValid: assert property (
        @(posedge clock) disable iff (rst)
        grp.groupSlots[0].valid && (pc[insnOffBits-1:0] == '0)
    );

endmodule

//--- wbFetchPort.sv
//------------------------------
// Wishbone classic read master. Fetches each valid
// slot of a group and offers it on valid/ready.
//------------------------------
`timescale 1ns/1ps
`include "fetch_defs.svh"

module wbFetchPort (
    input  logic            clock,
    input  logic            rst,
    groupIf.port            grp,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output wbPkg::WbAddr    wbAdr,
    output wbPkg::WbSel     wbSel,
    input  wbPkg::WbData    wbDatIn,
    input  logic            wbAck,
    output logic            outValid,
    input  logic            outReady,
    output fetchPkg::PcPath outPc,
    output wbPkg::WbData    outInsn,
    output logic            outPredTaken
);
    import fetchPkg::*;
    import wbPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stBus,
        stOut
    } PortState;

    PortState state;
    FetchSlot slots [`FETCH_WIDTH];
    SlotIdx   slotIdx;
    SlotIdx   nextIdx;
    logic     lastSlot;
    logic     dropping;

    assign wbWe = 1'b0;
    assign wbSel = wbSelAll;

    assign nextIdx = slotIdx + 1'b1;
    assign lastSlot = (slotIdx == SlotIdx'(`FETCH_WIDTH - 1)) || !slots[nextIdx].valid;

    assign grp.portIdle = (state == stIdle);
    assign grp.groupDone = (state == stOut) && outReady && lastSlot && !grp.redirectDrop;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= stIdle;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            outValid <= 1'b0;
            dropping <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (grp.groupTake) begin
                        slots <= grp.groupSlots;
                        slotIdx <= '0;
                        wbAdr <= grp.groupSlots[0].pc;
                        wbCyc <= 1'b1;
                        wbStb <= 1'b1;
                        dropping <= 1'b0;
                        state <= stBus;
                    end
                end
                stBus: begin
                    // A cycle cannot be abandoned, so remember the drop until ack
                    if (grp.redirectDrop) begin
                        dropping <= 1'b1;
                    end
                    if (wbAck) begin
                        wbCyc <= 1'b0;
                        wbStb <= 1'b0;
                        if (dropping || grp.redirectDrop) begin
                            state <= stIdle;
                        end else begin
                            outValid <= 1'b1;
                            outPc <= slots[slotIdx].pc;
                            outInsn <= wbDatIn;
                            outPredTaken <= slots[slotIdx].predTaken;
                            state <= stOut;
                        end
                    end
                end
                stOut: begin
                    if (grp.redirectDrop) begin
                        outValid <= 1'b0;
                        state <= stIdle;
                    end else if (outReady) begin
                        outValid <= 1'b0;
                        if (lastSlot) begin
                            state <= stIdle;
                        end else begin
                            slotIdx <= nextIdx;
                            wbAdr <= slots[nextIdx].pc;
                            wbCyc <= 1'b1;
                            wbStb <= 1'b1;
                            state <= stBus;
                        end
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Strobe only inside a cycle, and a cycle ends only on its ack
    stbInCyc: assert property (
        @(posedge clock) disable iff (rst)
        (!wbStb || wbCyc) && (!$fell(wbCyc) || $past(wbAck))
    );

    // Address and strobe stay put until the slave acks
    stbHeld: assert property (
        @(posedge clock) disable iff (rst)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr)
    );

    outHeld: assert property (
        @(posedge clock) disable iff (rst)
        outValid && !outReady |=>
            !outValid || ($stable(outPc) && $stable(outInsn) && $stable(outPredTaken))
    );

endmodule

//--- wbPkg.sv
//------------------------------
// Wishbone bus types used by the fetch port.
//------------------------------

package wbPkg;

    typedef logic [31:0] WbAddr;
    typedef logic [31:0] WbData;
    typedef logic [3:0]  WbSel;

    // Instruction reads always fetch the full word
    localparam WbSel wbSelAll = '1;

endpackage
